// File: hdl/ahb_pkg.sv
// Shared AHB-Lite types, transfer codes, address map and register offsets; import it where needed.
`default_nettype none

package ahb_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [1:0]  trans_t;
	typedef logic [15:0] region_t; // Upper address field, bits 31 to 16.
	typedef logic [7:0]  reg_off_t; // Byte offset inside the register block.

	localparam trans_t HTRANS_IDLE   = 2'b00;
	localparam trans_t HTRANS_BUSY   = 2'b01;
	localparam trans_t HTRANS_NONSEQ = 2'b10;
	localparam trans_t HTRANS_SEQ    = 2'b11;

	localparam region_t REGION_SRAM = 16'h0000;
	localparam region_t REGION_REGS = 16'h0001;

	localparam reg_off_t REG_CTRL    = 8'h00; // Bit 0 enables the interrupt.
	localparam reg_off_t REG_SCRATCH = 8'h04;
	localparam reg_off_t REG_STATUS  = 8'h08; // Bit 0 is pending, write 1 to clear.
	localparam reg_off_t REG_TRIGGER = 8'h0C; // Write bit 0 to set pending.

	typedef enum logic [1:0] {DEC_IDLE, DEC_ERR1, DEC_ERR2} dec_state_t;

	typedef enum logic {REG_IDLE, REG_WAIT} reg_state_t;

endpackage

`default_nettype wire

// File: hdl/ahb_slave_if.sv
// Bundle between the bus decoder and one downstream AHB-Lite slave, one instance per slave.
`timescale 1ns/1ps
`default_nettype none

interface ahb_slave_if;
	import ahb_pkg::*;

	logic   hsel;
	addr_t  haddr;
	trans_t htrans;
	logic   hwrite;
	data_t  hwdata;
	logic   hready; // Muxed ready, broadcast by the decoder.
	data_t  hrdata;
	logic   hreadyout;
	logic   hresp;

	modport decoder (
		output hsel, haddr, htrans, hwrite, hwdata, hready,
		input  hrdata, hreadyout, hresp
	);

	modport slave (
		input  hsel, haddr, htrans, hwrite, hwdata, hready,
		output hrdata, hreadyout, hresp
	);

endinterface

`default_nettype wire

// File: hdl/ahb_bus_decoder.sv
// AHB-Lite address decoder with response mux and default ERROR slave for unmapped regions.
`timescale 1ns/1ps
`default_nettype none

module ahb_bus_decoder (
	input  wire             hclk,
	input  wire             rst_n,
	input  wire             hsel,
	input  wire ahb_pkg::addr_t  haddr,
	input  wire ahb_pkg::trans_t htrans,
	input  wire             hwrite,
	input  wire ahb_pkg::data_t  hwdata,
	input  wire             hready,
	output ahb_pkg::data_t  hrdata,
	output logic            hreadyout,
	output logic            hresp,
	ahb_slave_if.decoder    sram_port,
	ahb_slave_if.decoder    regs_port
);
	import ahb_pkg::*;

	region_t    region;
	logic       active;
	logic       hit_sram;
	logic       hit_regs;
	logic       hit_none;
	logic       dp_sram; // SRAM owns the current data phase.
	logic       dp_regs; // Register block owns the current data phase.
	dec_state_t state;

	assign region   = haddr[31:16];
	assign active   = hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
	assign hit_sram = (region == REGION_SRAM);
	assign hit_regs = (region == REGION_REGS);
	assign hit_none = active && !hit_sram && !hit_regs;

	assign sram_port.hsel   = hsel && hit_sram;
	assign sram_port.haddr  = haddr;
	assign sram_port.htrans = htrans;
	assign sram_port.hwrite = hwrite;
	assign sram_port.hwdata = hwdata;
	assign sram_port.hready = hreadyout;

	assign regs_port.hsel   = hsel && hit_regs;
	assign regs_port.haddr  = haddr;
	assign regs_port.htrans = htrans;
	assign regs_port.hwrite = hwrite;
	assign regs_port.hwdata = hwdata;
	assign regs_port.hready = hreadyout;

	// The owner changes only when the previous data phase completes.
	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			dp_sram <= 1'b0;
			dp_regs <= 1'b0;
		end else if (hready) begin
			dp_sram <= active && hit_sram;
			dp_regs <= active && hit_regs;
		end
	end

	// Default slave, two-cycle ERROR response for unmapped addresses.
	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			state <= DEC_IDLE;
		end else begin
			case (state)
				DEC_ERR1: state <= DEC_ERR2;
				default: begin
					if (hready) begin
						state <= hit_none ? DEC_ERR1 : DEC_IDLE;
					end
				end
			endcase
		end
	end

	always_comb begin
		if (dp_sram) begin
			hrdata    = sram_port.hrdata;
			hreadyout = sram_port.hreadyout;
			hresp     = sram_port.hresp;
		end else if (dp_regs) begin
			hrdata    = regs_port.hrdata;
			hreadyout = regs_port.hreadyout;
			hresp     = regs_port.hresp;
		end else begin
			hrdata    = '0;
			hreadyout = (state != DEC_ERR1); // Wait cycle of the ERROR response.
			hresp     = (state != DEC_IDLE);
		end
	end

endmodule

`default_nettype wire

// File: hdl/ahb_sram_slave.sv
// Zero-wait-state word SRAM slave on the AHB-Lite decoder port; size set by SRAM_WORDS.
`timescale 1ns/1ps
`default_nettype none

module ahb_sram_slave #(
	parameter int SRAM_WORDS = 256
) (
	input  wire        hclk,
	input  wire        rst_n,
	ahb_slave_if.slave bus
);
	import ahb_pkg::*;

	localparam int IDX_W = $clog2(SRAM_WORDS);

	typedef logic [IDX_W-1:0] idx_t;

	data_t mem [SRAM_WORDS];
	idx_t  idx_q;
	logic  wr_q;
	logic  accept;

	assign accept = bus.hsel && bus.htrans[1] && bus.hready;

	// Word index wraps modulo SRAM_WORDS.
	always_ff @(posedge hclk) begin
		if (accept) begin
			idx_q <= bus.haddr[IDX_W+1:2];
		end
	end

	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			wr_q <= 1'b0;
		end else if (bus.hready) begin
			wr_q <= accept && bus.hwrite;
		end
	end

	always_ff @(posedge hclk) begin
		if (wr_q) begin
			mem[idx_q] <= bus.hwdata; // Write data is valid in the data phase.
		end
	end

	assign bus.hrdata    = mem[idx_q];
	assign bus.hreadyout = 1'b1;
	assign bus.hresp     = 1'b0;

endmodule

`default_nettype wire

// File: hdl/ahb_irq_regs.sv
// Register slave with one wait state, control, scratch and pending status, driving an interrupt.
`timescale 1ns/1ps
`default_nettype none

module ahb_irq_regs (
	input  wire        hclk,
	input  wire        rst_n,
	ahb_slave_if.slave bus,
	output logic       irq
);
	import ahb_pkg::*;

	reg_state_t state;
	reg_off_t   off_q;
	logic       wr_q;
	logic       xfer_q; // Last cycle of a data phase.
	logic       accept;
	logic       enable;
	logic       pending;
	data_t      scratch;

	assign accept = (state == REG_IDLE) && bus.hsel && bus.htrans[1] && bus.hready;

	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			state  <= REG_IDLE;
			xfer_q <= 1'b0;
		end else begin
			xfer_q <= (state == REG_WAIT);
			case (state)
				REG_IDLE: state <= accept ? REG_WAIT : REG_IDLE;
				default:  state <= REG_IDLE;
			endcase
		end
	end

	always_ff @(posedge hclk) begin
		if (accept) begin
			off_q <= bus.haddr[7:0];
			wr_q  <= bus.hwrite;
		end
	end

	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			enable  <= 1'b0;
			scratch <= '0;
			pending <= 1'b0;
			irq     <= 1'b0;
		end else begin
			irq <= enable && pending;
			if (xfer_q && wr_q) begin
				case (off_q)
					REG_CTRL:    enable  <= bus.hwdata[0];
					REG_SCRATCH: scratch <= bus.hwdata;
					REG_STATUS:  pending <= pending && !bus.hwdata[0];
					REG_TRIGGER: pending <= pending || bus.hwdata[0];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (off_q)
			REG_CTRL:    bus.hrdata = {31'b0, enable};
			REG_SCRATCH: bus.hrdata = scratch;
			REG_STATUS:  bus.hrdata = {31'b0, pending};
			default:     bus.hrdata = '0;
		endcase
	end

	assign bus.hreadyout = (state != REG_WAIT);
	assign bus.hresp     = 1'b0;

endmodule

`default_nettype wire

// File: hdl/ahb_subsystem.sv
// Top level of the AHB-Lite peripheral subsystem, one upstream slave port and an interrupt.
`timescale 1ns/1ps
`default_nettype none

module ahb_subsystem #(
	parameter int SRAM_WORDS = 256
) (
	input  wire                  hclk,
	input  wire                  rst_n,
	input  wire                  hsel,
	input  wire ahb_pkg::addr_t  haddr,
	input  wire ahb_pkg::trans_t htrans,
	input  wire                  hwrite,
	input  wire ahb_pkg::data_t  hwdata,
	input  wire                  hready,
	output wire ahb_pkg::data_t  hrdata,
	output wire                  hreadyout,
	output wire                  hresp,
	output wire                  irq
);

	ahb_slave_if sram_if ();
	ahb_slave_if regs_if ();

	ahb_bus_decoder ahb_bus_decoder_inst (
		.hclk      (hclk),
		.rst_n     (rst_n),
		.hsel      (hsel),
		.haddr     (haddr),
		.htrans    (htrans),
		.hwrite    (hwrite),
		.hwdata    (hwdata),
		.hready    (hready),
		.hrdata    (hrdata),
		.hreadyout (hreadyout),
		.hresp     (hresp),
		.sram_port (sram_if),
		.regs_port (regs_if)
	);

	ahb_sram_slave #(
		.SRAM_WORDS (SRAM_WORDS)
	) ahb_sram_slave_inst (
		.hclk  (hclk),
		.rst_n (rst_n),
		.bus   (sram_if)
	);

	ahb_irq_regs ahb_irq_regs_inst (
		.hclk  (hclk),
		.rst_n (rst_n),
		.bus   (regs_if),
		.irq   (irq)
	);

endmodule

`default_nettype wire

// File: verif/ahb_subsystem_chk.sv
// Protocol assertions for the AHB-Lite bus decoder, attached to every decoder instance by bind.
`timescale 1ns/1ps
`default_nettype none

module ahb_subsystem_chk (
	input wire hclk,
	input wire rst_n,
	input wire sram_sel,
	input wire regs_sel,
	input wire err_sel, // The default slave owns the data phase.
	input wire hreadyout,
	input wire hresp
);
	int fail_count = 0; // Read by the testbench at the end of the run.

	a_one_select: assert property (@(posedge hclk) disable iff (!rst_n)
		$onehot0({sram_sel, regs_sel, err_sel}))
		else begin
			fail_count = fail_count + 1;
			$error("More than one slave owns the data phase.");
		end

	a_ready_after_reset: assert property (@(posedge hclk) !rst_n |=> hreadyout)
		else begin
			fail_count = fail_count + 1;
			$error("hreadyout is low after reset.");
		end

	// The ERROR response takes two cycles, the first one with a wait.
	a_error_two_cycles: assert property (@(posedge hclk) disable iff (!rst_n)
		(hresp && !hreadyout) |=> (hresp && hreadyout))
		else begin
			fail_count = fail_count + 1;
			$error("ERROR response lacks its second cycle.");
		end

endmodule

bind ahb_bus_decoder ahb_subsystem_chk chk_inst (
	.hclk      (hclk),
	.rst_n     (rst_n),
	.sram_sel  (dp_sram),
	.regs_sel  (dp_regs),
	.err_sel   (state != ahb_pkg::DEC_IDLE),
	.hreadyout (hreadyout),
	.hresp     (hresp)
);

`default_nettype wire

// File: verif/tb_ahb_subsystem.sv
// Self-checking testbench for the AHB-Lite subsystem; acts as the bus master and runs from src.f.
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_subsystem;
	import ahb_pkg::*;

	localparam int SRAM_WORDS = 256;
	localparam int IDX_W      = $clog2(SRAM_WORDS);
	localparam int MAX_CYCLES = 4000; // About 700 cycles of traffic, with a wide margin.

	typedef struct packed {
		addr_t      addr;
		logic       wr;
		data_t      wdata;
		data_t      rdata;
		logic       resp;
		logic       wait_resp; // hresp seen in the last wait cycle.
		logic [3:0] waits;
	} xfer_t;

	logic   hclk = 1'b0;
	logic   rst_n;
	logic   hsel;
	addr_t  haddr;
	trans_t htrans;
	logic   hwrite;
	data_t  hwdata;
	wire    hready;
	data_t  hrdata;
	logic   hreadyout;
	logic   hresp;
	logic   irq;
	xfer_t  pend_q[$];
	xfer_t  done_q[$];
	data_t  model_mem [SRAM_WORDS];
	logic   model_en;
	logic   model_pend;
	data_t  model_scratch;
	data_t  rng = 32'd33;
	int     cycle_count = 0;

	assign hready = hreadyout; // The master follows the muxed ready.

	ahb_subsystem #(.SRAM_WORDS (SRAM_WORDS)) ahb_subsystem_inst (.*);

	always #5 hclk = ~hclk;

	always @(posedge hclk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the test did not finish within %0d cycles.", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Simulation timed out.");
		end
	end

	function automatic data_t next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic addr_t reg_addr(reg_off_t off);
		return {REGION_REGS, 8'h00, off};
	endfunction

	function automatic data_t model_read(addr_t addr);
		if (addr[31:16] == REGION_SRAM) return model_mem[addr[IDX_W+1:2]];
		if (addr[31:16] != REGION_REGS) return '0;
		case (addr[7:0])
			REG_CTRL:    return {31'b0, model_en};
			REG_SCRATCH: return model_scratch;
			REG_STATUS:  return {31'b0, model_pend};
			default:     return '0; // Trigger and holes read as zero.
		endcase
	endfunction

	task automatic model_write(addr_t addr, data_t data);
		if (addr[31:16] == REGION_SRAM) begin
			model_mem[addr[IDX_W+1:2]] = data;
		end else if (addr[31:16] == REGION_REGS) begin
			case (addr[7:0])
				REG_CTRL:    model_en = data[0];
				REG_SCRATCH: model_scratch = data;
				REG_STATUS:  model_pend = model_pend && !data[0];
				REG_TRIGGER: model_pend = model_pend || data[0];
				default: ;
			endcase
		end
	endtask

	task automatic report_mismatch(string name, addr_t addr, data_t got, data_t exp);
		$display("CHECK FAILED %s (haddr 0x%08h): got 0x%08h, expected 0x%08h", name, addr, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Mismatch on %s.", name);
	endtask

	task automatic queue_xfer(addr_t addr, logic wr, data_t wdata);
		xfer_t t;
		t       = '0;
		t.addr  = addr;
		t.wr    = wr;
		t.wdata = wdata;
		pend_q.push_back(t);
	endtask

	// Issues the queued transfers back to back, address phase overlapping the data phase.
	task automatic run_queue();
		xfer_t cur;
		xfer_t dp;
		logic  cur_v;
		logic  dp_v;
		logic  rdy;
		logic  rsp;
		data_t rd;
		dp    = '0;
		dp_v  = 1'b0;
		cur   = '0;
		cur_v = (pend_q.size() > 0);
		if (cur_v) cur = pend_q.pop_front();
		while (cur_v || dp_v) begin
			haddr  = cur.addr;
			htrans = cur_v ? HTRANS_NONSEQ : HTRANS_IDLE;
			hwrite = cur.wr;
			hwdata = dp.wdata;
			@(negedge hclk);
			rdy = hreadyout;
			rsp = hresp;
			rd  = hrdata;
			@(posedge hclk);
			#1;
			if (!rdy) begin
				dp.waits     = dp.waits + 4'd1;
				dp.wait_resp = rsp;
			end else begin
				if (dp_v) begin
					dp.rdata = rd;
					dp.resp  = rsp;
					done_q.push_back(dp);
				end
				dp    = cur;
				dp_v  = cur_v;
				cur   = '0;
				cur_v = (pend_q.size() > 0);
				if (cur_v) cur = pend_q.pop_front();
			end
		end
		htrans = HTRANS_IDLE;
	endtask

	task automatic check_irq(logic exp);
		repeat (3) @(posedge hclk);
		@(negedge hclk);
		assert (irq == exp) else report_mismatch("irq", '0, {31'b0, irq}, {31'b0, exp});
		@(posedge hclk);
		#1;
	endtask

	initial begin : compare_results
		xfer_t      t;
		logic       unmapped;
		logic [3:0] exp_waits;
		forever begin
			@(posedge hclk);
			while (done_q.size() > 0) begin
				t         = done_q.pop_front();
				unmapped  = (t.addr[31:16] != REGION_SRAM) && (t.addr[31:16] != REGION_REGS);
				exp_waits = (t.addr[31:16] == REGION_SRAM) ? 4'd0 : 4'd1;
				assert (t.resp == unmapped)
					else report_mismatch("hresp", t.addr, {31'b0, t.resp}, {31'b0, unmapped});
				assert (t.waits == exp_waits)
					else report_mismatch("wait cycles", t.addr, {28'b0, t.waits}, {28'b0, exp_waits});
				assert (t.wait_resp == unmapped)
					else report_mismatch("hresp in wait", t.addr, {31'b0, t.wait_resp}, {31'b0, unmapped});
				if (!t.wr) begin
					assert (t.rdata == model_read(t.addr))
						else report_mismatch("hrdata", t.addr, t.rdata, model_read(t.addr));
				end else if (!unmapped) begin
					model_write(t.addr, t.wdata);
				end
			end
		end
	end

	initial begin : main_sequence
		data_t r;
		addr_t a;
		int    i;
		rst_n         = 1'b0;
		hsel          = 1'b0;
		haddr         = '0;
		htrans        = HTRANS_IDLE;
		hwrite        = 1'b0;
		hwdata        = '0;
		model_en      = 1'b0;
		model_pend    = 1'b0;
		model_scratch = '0;
		repeat (8) @(posedge hclk);
		#1;
		rst_n = 1'b1;
		hsel  = 1'b1;
		@(negedge hclk);
		assert ({hreadyout, hresp, irq} == 3'b100)
			else report_mismatch("hreadyout,hresp,irq", '0, {29'b0, hreadyout, hresp, irq}, 32'h4);
		@(posedge hclk);
		#1;
		for (i = 0; i < 4; i++) queue_xfer(reg_addr(reg_off_t'(i * 4)), 1'b0, '0);
		run_queue();
		for (i = 0; i < SRAM_WORDS; i++) begin
			r = next_random();
			a = {REGION_SRAM, r[15:0]}; // Random upper bits exercise the aliasing.
			a[IDX_W+1:0] = {i[IDX_W-1:0], 2'b00};
			queue_xfer(a, 1'b1, next_random());
		end
		for (i = 0; i < 200; i++) begin
			r = next_random();
			queue_xfer({REGION_SRAM, r[15:2], 2'b00}, r[0], next_random());
		end
		run_queue();
		for (i = 0; i < 10; i++) begin
			queue_xfer(reg_addr(REG_SCRATCH), 1'b1, next_random());
			queue_xfer(reg_addr(REG_SCRATCH), 1'b0, '0);
		end
		run_queue();
		queue_xfer(reg_addr(REG_TRIGGER), 1'b1, 32'h1);
		queue_xfer(reg_addr(REG_STATUS), 1'b0, '0);
		queue_xfer(reg_addr(REG_TRIGGER), 1'b0, '0);
		run_queue();
		check_irq(1'b0); // Pending alone must not raise irq.
		queue_xfer(reg_addr(REG_CTRL), 1'b1, 32'h1);
		queue_xfer(reg_addr(REG_CTRL), 1'b0, '0);
		run_queue();
		check_irq(1'b1);
		queue_xfer(reg_addr(REG_STATUS), 1'b1, 32'h1);
		queue_xfer(reg_addr(REG_STATUS), 1'b0, '0);
		run_queue();
		check_irq(1'b0);
		queue_xfer({16'h8001, 8'h00, REG_SCRATCH}, 1'b1, 32'hdead_beef);
		queue_xfer({16'h0002, 16'h0010}, 1'b1, 32'h1234_5678);
		queue_xfer({16'hffff, 16'h0000}, 1'b0, '0);
		queue_xfer(reg_addr(REG_SCRATCH), 1'b0, '0);
		queue_xfer({REGION_SRAM, 16'h0010}, 1'b0, '0);
		run_queue();
		for (i = 0; i < 60; i++) begin
			r = next_random();
			case (r[1:0])
				2'd1:    a = reg_addr(REG_SCRATCH);
				2'd2:    a = {1'b1, r[30:16], 16'h0000};
				default: a = {REGION_SRAM, r[17:4], 2'b00};
			endcase
			queue_xfer(a, r[2], next_random());
		end
		run_queue();
		repeat (4) @(posedge hclk);
		if (done_q.size() == 0 && ahb_subsystem_inst.ahb_bus_decoder_inst.chk_inst.fail_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("Protocol assertions failed or completed transfers were left unchecked.");
			$display("TEST RESULT: FAIL");
			$fatal(1, "Run ended with errors.");
		end
	end

endmodule

`default_nettype wire

// File: src.f
hdl/ahb_pkg.sv
hdl/ahb_slave_if.sv
hdl/ahb_bus_decoder.sv
hdl/ahb_sram_slave.sv
hdl/ahb_irq_regs.sv
hdl/ahb_subsystem.sv
verif/ahb_subsystem_chk.sv
verif/tb_ahb_subsystem.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ahb_subsystem
FILELIST  = src.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
